// File: Makefile
TOP := sccb_rx_bridge_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f sccb_rx_bridge.f -Mdir obj_dir -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// File: bench/sccb_rx_bridge_tb.sv
`default_nettype none

module sccb_rx_bridge_tb
	import sccb_pkg::*;
();

	localparam int CREDIT_INIT = 2;
	// Cycles any single wait may take
	localparam int WAIT_LIMIT  = 300;

	logic       rx_clk;
	logic       arst_n;
	logic       link_up;
	ll_word_t   ll_in;
	apb_in_t    apb_in;
	logic       credit_return;
	apb_out_t   apb_out;
	ack_t       ack;
	comp_word_t comp_out;

	int seed = 32'heaba_9a68;

	// Current vector fields
	int          fd;
	string       line;
	string       kind;
	logic [31:0] addr;
	logic [31:0] data;
	int          err;
	int          nwords;
	logic [31:0] exp_data;
	int          exp_err;

	// Expected traffic as {start, word} and {error, data}
	logic [32:0] exp_comp[$];
	logic [32:0] exp_ack[$];
	int          comp_rd;
	int          ack_rd;
	logic        tail_due;

	// APB completer state
	logic [31:0] resp_data;
	logic        resp_err;
	int          apb_wait;
	int          apb_count;
	logic        last_pwrite;
	logic [31:0] last_paddr;
	logic [31:0] last_pwdata;
	logic [3:0]  last_pstrb;

	// Credit receiver state
	logic        withhold;
	int          owed;
	int          gap;
	int          total_starts;
	int          starts_before;

	sccb_rx_bridge #(
		.CREDIT_INIT (CREDIT_INIT)
	) i_sccb_rx_bridge (
		.rx_clk        (rx_clk),
		.arst_n        (arst_n),
		.link_up       (link_up),
		.ll_in         (ll_in),
		.apb_in        (apb_in),
		.credit_return (credit_return),
		.apb_out       (apb_out),
		.ack           (ack),
		.comp_out      (comp_out)
	);

	initial begin
		rx_clk = 1'b0;
		forever #2 rx_clk = ~rx_clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Failure handling

	task automatic abort_run(input string why);
		$display("%s at time %0t", why, $time);
		$display("Test failed");
		$fatal;
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("Test failed");
			$fatal;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Bus models sampled on the rising edge

	// Completer with 0 to 3 wait states
	task automatic apb_step();
		apb_in.pready  <= 1'b0;
		apb_in.pslverr <= 1'b0;
		if (apb_out.psel && apb_out.penable && apb_in.pready) begin
			// Transfer ends on this edge
			last_pwrite = apb_out.pwrite;
			last_paddr  = apb_out.paddr;
			last_pwdata = apb_out.pwdata;
			last_pstrb  = apb_out.pstrb;
			apb_count++;
		end else if (apb_out.psel) begin
			if (!apb_out.penable)
				apb_wait = int'($unsigned($random(seed)) % 4);
			else
				apb_wait = apb_wait - 1;
			if (apb_wait <= 0) begin
				apb_in.pready  <= 1'b1;
				apb_in.pslverr <= resp_err;
				apb_in.prdata  <= resp_data;
			end
		end
	endtask

	// Receiver hands back one credit per frame after a random gap
	task automatic credit_step();
		credit_return <= 1'b0;
		if (comp_out.valid && comp_out.start) begin
			check(32'(owed < CREDIT_INIT), 32'd1, "frame start within credit");
			if (owed == 0)
				gap = int'($unsigned($random(seed)) % 6);
			owed++;
			total_starts++;
		end
		if (gap > 0)
			gap = gap - 1;
		else if (owed > 0 && !withhold) begin
			credit_return <= 1'b1;
			owed--;
			gap = int'($unsigned($random(seed)) % 6);
		end
	endtask

	task automatic comp_monitor_step();
		// Data frames carry their second word straight after the first
		if (tail_due)
			check(32'(comp_out.valid && !comp_out.start), 32'd1, "completion tail word");
		tail_due = 1'b0;
		if (comp_out.valid) begin
			if (comp_rd >= exp_comp.size()) begin
				abort_run("Completion word sent that no transaction asked for");
			end else begin
				check(32'(comp_out.start), 32'(exp_comp[comp_rd][32]), "completion start");
				check(comp_out.data, exp_comp[comp_rd][31:0], "completion word");
				tail_due = comp_out.start && (comp_out.data[7:0] == 8'hfd);
				comp_rd++;
			end
		end
	endtask

	task automatic ack_monitor_step();
		if (ack.valid) begin
			if (ack_rd >= exp_ack.size()) begin
				abort_run("Ack raised for a frame that should give none");
			end else begin
				check(ack.data, exp_ack[ack_rd][31:0], "ack data");
				check(32'(ack.error), 32'(exp_ack[ack_rd][32]), "ack error");
				ack_rd++;
			end
		end
	endtask

	initial begin
		apb_in        <= '0;
		credit_return <= 1'b0;
		apb_wait      = 0;
		apb_count     = 0;
		owed          = 0;
		gap           = 0;
		total_starts  = 0;
		comp_rd       = 0;
		ack_rd        = 0;
		tail_due      = 1'b0;
		forever begin
			@(posedge rx_clk);
			apb_step();
			credit_step();
			comp_monitor_step();
			ack_monitor_step();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Link driver and waits

	// Ending 0 commits, 1 drops, 2 lowers link_up during word 1
	task automatic send_frame(input logic [31:0] w0, input logic [31:0] w1,
			input logic [31:0] w2, input int n, input int ending);
		logic [31:0] w [3];
		int i;
		w[0] = w0;
		w[1] = w1;
		w[2] = w2;
		for (i = 0; i < n; i++) begin
			@(posedge rx_clk);
			ll_in   <= '{start: (i == 0), valid: 1'b1, commit: 1'b0, drop: 1'b0, data: w[i]};
			link_up <= !(ending == 2 && i == 1);
		end
		@(posedge rx_clk);
		ll_in   <= '{start: 1'b0, valid: 1'b0, commit: (ending != 1), drop: (ending == 1),
			data: 32'h0};
		link_up <= 1'b1;
		@(posedge rx_clk);
		ll_in   <= '0;
	endtask

	task automatic wait_apb(input int target);
		int n;
		n = 0;
		while (apb_count < target) begin
			@(posedge rx_clk);
			n++;
			if (n > WAIT_LIMIT)
				abort_run("Timed out waiting for an APB transfer");
		end
	endtask

	task automatic drain_pending(input logic need_credits);
		int n;
		n = 0;
		while (comp_rd < exp_comp.size() || ack_rd < exp_ack.size() ||
				(need_credits && owed != 0)) begin
			@(posedge rx_clk);
			n++;
			if (n > WAIT_LIMIT)
				abort_run("Timed out waiting for completions, acks or credit returns");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One vector line

	task automatic run_vector();
		int          apb_before;
		logic        is_write;
		logic [31:0] w0;
		logic [31:0] w1;
		logic [31:0] w2;
		apb_before = apb_count;
		is_write   = (kind == "write");
		// Request layout with high address and data bytes first
		w0 = {addr[23:16], addr[31:24], 8'h00, is_write ? 8'hfb : 8'h1c};
		w1 = {is_write ? {data[23:16], data[31:24]} : 16'h0000, addr[7:0], addr[15:8]};
		w2 = {16'h0000, data[7:0], data[15:8]};

		if (kind == "hold") begin
			if (err != 0) begin
				drain_pending(1'b1);
				starts_before = total_starts;
				withhold      = 1'b1;
			end else begin
				// Third completion must still be parked
				repeat (12) @(posedge rx_clk);
				check(total_starts - starts_before, CREDIT_INIT, "frame starts while withheld");
				withhold = 1'b0;
				drain_pending(1'b0);
			end
		end else if (kind == "write" || kind == "read") begin
			resp_data = is_write ? 32'h0 : data;
			resp_err  = (err != 0);
			if (nwords == 2) begin
				exp_comp.push_back({1'b1, exp_data[23:16], exp_data[31:24], 8'h00, 8'hfd});
				exp_comp.push_back({1'b0, 16'h0000, exp_data[7:0], exp_data[15:8]});
			end else begin
				exp_comp.push_back({1'b1, 15'd0, (exp_err == 0), 8'h00, 8'hf7});
			end
			send_frame(w0, w1, w2, is_write ? 3 : 2, 0);
			wait_apb(apb_before + 1);
			check(32'(last_pwrite), 32'(is_write), "pwrite");
			check(last_paddr, addr, "paddr");
			check(32'(last_pstrb), is_write ? 32'hf : 32'h0, "pstrb");
			if (is_write)
				check(last_pwdata, data, "pwdata");
			// Blocked completions are collected at the hold release
			if (!withhold) begin
				drain_pending(1'b0);
				check(apb_count, apb_before + 1, "APB transfer count");
			end
		end else if (kind == "comp_data" || kind == "comp_empty") begin
			exp_ack.push_back({(exp_err != 0), exp_data});
			if (kind == "comp_data")
				send_frame({data[23:16], data[31:24], 8'h00, 8'hfd},
					{16'h0000, data[7:0], data[15:8]}, 32'h0, 2, 0);
			else
				send_frame({15'd0, (err == 0), 8'h00, 8'hf7}, 32'h0, 32'h0, 1, 0);
			drain_pending(1'b0);
			check(apb_count, apb_before, "APB transfers after completion frame");
		end else begin
			// Monitors flag any ack or completion from a discarded frame
			if (kind == "drop")
				send_frame(w0, w1, w2, 3, 1);
			else if (kind == "linkdown")
				send_frame(w0, w1, w2, 3, 2);
			else
				send_frame({w0[31:8], 8'h55}, w1, w2, 3, 0);
			repeat (12) @(posedge rx_clk);
			check(apb_count, apb_before, "APB transfers after discarded frame");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		arst_n    <= 1'b0;
		link_up   <= 1'b1;
		ll_in     <= '0;
		withhold  = 1'b0;
		resp_data = 32'h0;
		resp_err  = 1'b0;
		fd = $fopen("bench/sccb_rx_vectors.txt", "r");
		if (fd == 0)
			abort_run("Cannot open bench/sccb_rx_vectors.txt");

		repeat (5) @(posedge rx_clk);
		check(32'(apb_out.psel || apb_out.penable), 32'd0, "APB select in reset");
		check(32'(ack.valid), 32'd0, "ack valid in reset");
		check(32'(comp_out.valid), 32'd0, "completion valid in reset");
		arst_n <= 1'b1;

		while ($fgets(line, fd) != 0) begin
			// Skip column notes and blank lines
			if (line.len() > 1 && line.getc(0) != "#") begin
				if ($sscanf(line, "%s %h %h %d %d %h %d", kind, addr, data, err, nwords,
						exp_data, exp_err) != 7)
					abort_run("Malformed line in the vector file");
				run_vector();
			end
		end
		$fclose(fd);
		drain_pending(1'b0);

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/sccb_rx_vectors.txt
# kind addr data err | exp_words exp_data exp_err   (hex for addr and data columns)
# data is wdata, prdata or sent completion data; err is pslverr, ack error or hold on/off
write      10000004 deadbeef 0 1 00000000 0
read       10000004 cafef00d 0 2 cafef00d 0
write      2000fff0 01234567 1 1 00000000 1
read       20000010 89abcdef 1 1 00000000 1
read       20000014 a5a51234 0 2 a5a51234 0
comp_data  00000000 13572468 0 0 13572468 0
comp_empty 00000000 00000000 0 0 00000000 0
comp_empty 00000000 00000000 1 0 00000000 1
comp_data  00000000 fedcba98 0 0 fedcba98 0
drop       30000000 11111111 0 0 00000000 0
unknown    30000004 22222222 0 0 00000000 0
write      30000008 33333333 0 1 00000000 0
linkdown   3000000c 44444444 0 0 00000000 0
write      4000000c 55555555 0 1 00000000 0
read       4000000c 0badf00d 0 2 0badf00d 0
hold       00000000 00000000 1 0 00000000 0
write      50000000 66666666 0 1 00000000 0
read       50000004 77777777 0 2 77777777 0
write      50000008 88888888 1 1 00000000 1
hold       00000000 00000000 0 0 00000000 0
read       60000000 0f0f0f0f 0 2 0f0f0f0f 0
write      60000004 c001d00d 0 1 00000000 0
comp_empty 00000000 00000000 0 0 00000000 0
read       70000000 12345678 1 1 00000000 1

// File: rtl/sccb_apb_requester.sv
`default_nettype none

module sccb_apb_requester
	import sccb_pkg::*;
(
	input wire               rx_clk,
	input wire               arst_n,
	input wire apb_request_t req,
	input wire               req_valid,
	output logic             req_ready,
	output apb_out_t         apb_out,
	input wire apb_in_t      apb_in,
	output completion_t      cmp,
	output logic             cmp_valid,
	input wire               cmp_ready
);

	// Report also serves as idle once the completion is gone
	typedef enum logic [1:0] {
		ST_REPORT,
		ST_SETUP,
		ST_ACCESS
	} state_e;

	state_e       state;
	// Request under execution
	apb_request_t cur;
	logic         req_take;
	logic         apb_done;

	////////////////////////////////////////////////////////////////////////////
	// Handshakes

	// One transaction at a time, and only after the last report left
	assign req_ready = (state == ST_REPORT) && !cmp_valid;
	assign req_take  = req_valid && req_ready;

	// Access phase ends on the first ready
	assign apb_done = (state == ST_ACCESS) && apb_in.pready;

	////////////////////////////////////////////////////////////////////////////
	// Setup / access / report FSM

	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_REPORT;
			cmp_valid <= 1'b0;
		end else begin
			case (state)
				ST_REPORT: begin
					if (cmp_valid && cmp_ready)
						cmp_valid <= 1'b0;
					if (req_take)
						state <= ST_SETUP;
				end
				// Setup lasts exactly one cycle
				ST_SETUP: state <= ST_ACCESS;
				// Wait states until the completer is ready
				ST_ACCESS: begin
					if (apb_done) begin
						state     <= ST_REPORT;
						cmp_valid <= 1'b1;
					end
				end
				default: state <= ST_REPORT;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Request capture and completion record

	always_ff @(posedge rx_clk) begin
		if (req_take)
			cur <= req;

		if (apb_done) begin
			// Only a clean read returns data
			cmp.has_data <= !cur.write && !apb_in.pslverr;
			cmp.success  <= !apb_in.pslverr;
			cmp.data     <= apb_in.prdata;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// APB outputs

	always_comb begin
		apb_out.psel    = (state != ST_REPORT);
		apb_out.penable = (state == ST_ACCESS);
		apb_out.pwrite  = cur.write;
		apb_out.paddr   = cur.addr;
		apb_out.pwdata  = cur.wdata;
		// Full word writes, no strobes on reads
		apb_out.pstrb   = cur.write ? 4'hf : 4'h0;
	end

endmodule

`default_nettype wire

// File: rtl/sccb_completion_encoder.sv
`default_nettype none

module sccb_completion_encoder
	import sccb_pkg::*;
#(
	parameter int CREDIT_INIT = 2
) (
	input wire              rx_clk,
	input wire              arst_n,
	input wire completion_t cmp,
	input wire              cmp_valid,
	output logic            cmp_ready,
	input wire              credit_return,
	output comp_word_t      comp_out
);

	// Counter wide enough for the initial grant
	localparam int CW = (CREDIT_INIT < 1) ? 1 : $clog2(CREDIT_INIT + 1);

	typedef enum logic {
		ST_IDLE,
		ST_TAIL
	} state_e;

	state_e       state;
	logic [CW-1:0] credits;
	logic         take;

	// Completion being sent, for the second word
	completion_t  held;
	comp_header_t hdr_next;

	logic         out_start;
	logic         out_valid;
	logic [31:0]  out_data;

	////////////////////////////////////////////////////////////////////////////
	// Acceptance

	// New frame only between frames and with a credit in hand
	assign cmp_ready = (state == ST_IDLE) && (credits != '0);
	assign take      = cmp_valid && cmp_ready;

	// Word 0 of the frame for the completion on the input
	always_comb begin
		hdr_next.frame_type = cmp.has_data ? FRAME_COMP_DATA : FRAME_COMP_EMPTY;
		// Sequence number always zero
		hdr_next.seq        = 8'h00;
		if (cmp.has_data)
			hdr_next.status = swap_bytes(cmp.data[31:16]);
		else
			hdr_next.status = {15'd0, cmp.success};
	end

	////////////////////////////////////////////////////////////////////////////
	// Frame FSM and credits

	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			credits   <= CW'(CREDIT_INIT);
			out_start <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			out_start <= 1'b0;
			out_valid <= 1'b0;

			case (state)
				ST_IDLE: begin
					if (take) begin
						out_start <= 1'b1;
						out_valid <= 1'b1;
						// Data frames need a second word
						if (cmp.has_data)
							state <= ST_TAIL;
					end
				end
				ST_TAIL: begin
					out_valid <= 1'b1;
					state     <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase

			// Return and spend in one cycle cancel out
			case ({credit_return, take})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Word data

	always_ff @(posedge rx_clk) begin
		if (take) begin
			held     <= cmp;
			out_data <= hdr_next;
		end else if (state == ST_TAIL) begin
			// Low data bytes, upper half zero
			out_data <= {16'h0000, swap_bytes(held.data[15:0])};
		end
	end

	assign comp_out = '{start: out_start, valid: out_valid, data: out_data};

endmodule

`default_nettype wire

// File: rtl/sccb_frame_decoder.sv
`default_nettype none

module sccb_frame_decoder
	import sccb_pkg::*;
(
	input wire               rx_clk,
	input wire               arst_n,
	input wire               link_up,
	input wire ll_word_t     ll_in,
	input wire               req_ready,
	output apb_request_t     req,
	output logic             req_valid,
	output ack_t             ack
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_REQ_WORD,
		ST_WR_DATA,
		ST_AWAIT_COMMIT,
		ST_COMP_WORD
	} state_e;

	state_e       state;
	// Frame in flight is a completion, not a request
	logic         is_ack;

	// Assembly registers, filled word by word
	apb_request_t asm_req;
	logic         asm_ack_error;
	logic [31:0]  asm_ack_data;

	// Ack output registers
	logic         ack_valid;
	logic         ack_error;
	logic [31:0]  ack_data;

	frame_header_u hdr;
	frame_type_e   hdr_type;
	logic          word_ok;
	logic          commit_now;
	logic          load_req;
	logic          load_ack;

	////////////////////////////////////////////////////////////////////////////
	// Header view and commit decode

	assign hdr      = ll_in.data;
	assign hdr_type = frame_type_e'(hdr.req.frame_type);

	// Continuation word is good if present and not dropped
	assign word_ok = ll_in.valid && !ll_in.drop;

	// Drop wins over commit in the same cycle
	assign commit_now = link_up && (state == ST_AWAIT_COMMIT) && ll_in.commit && !ll_in.drop;

	// Request hold still full means the new request is lost
	assign load_req = commit_now && !is_ack && !req_valid;
	assign load_ack = commit_now && is_ack;

	////////////////////////////////////////////////////////////////////////////
	// Frame FSM

	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			is_ack    <= 1'b0;
			req_valid <= 1'b0;
			ack_valid <= 1'b0;
		end else begin
			// Ack is a single cycle pulse
			ack_valid <= load_ack;

			// Hold empties on handoff, refills on commit
			if (load_req)
				req_valid <= 1'b1;
			else if (req_valid && req_ready)
				req_valid <= 1'b0;

			if (!link_up) begin
				// Link lost, abandon whatever was in progress
				state <= ST_IDLE;
			end else begin
				case (state)
					ST_IDLE: begin
						if (ll_in.start && ll_in.valid) begin
							case (hdr_type)
								FRAME_APB_WRITE, FRAME_APB_READ: begin
									is_ack <= 1'b0;
									state  <= ST_REQ_WORD;
								end
								FRAME_COMP_DATA: begin
									is_ack <= 1'b1;
									state  <= ST_COMP_WORD;
								end
								// Single word frame, straight to commit
								FRAME_COMP_EMPTY: begin
									is_ack <= 1'b1;
									state  <= ST_AWAIT_COMMIT;
								end
								// Unknown type, ignore the frame
								default: state <= ST_IDLE;
							endcase
						end
					end

					// Low address, maybe high write data
					ST_REQ_WORD: begin
						if (!word_ok)
							state <= ST_IDLE;
						else if (asm_req.write)
							state <= ST_WR_DATA;
						else
							state <= ST_AWAIT_COMMIT;
					end

					// Low write data
					ST_WR_DATA: begin
						if (!word_ok)
							state <= ST_IDLE;
						else
							state <= ST_AWAIT_COMMIT;
					end

					// Low completion data
					ST_COMP_WORD: begin
						if (!word_ok)
							state <= ST_IDLE;
						else
							state <= ST_AWAIT_COMMIT;
					end

					ST_AWAIT_COMMIT: begin
						if (ll_in.drop || ll_in.commit)
							state <= ST_IDLE;
					end

					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Field assembly

	always_ff @(posedge rx_clk) begin
		case (state)
			ST_IDLE: begin
				if (ll_in.start && ll_in.valid) begin
					asm_req.write       <= (hdr_type == FRAME_APB_WRITE);
					asm_req.addr[31:16] <= {hdr.req.addr_b3, hdr.req.addr_b2};
					// Reads carry no data
					asm_req.wdata       <= '0;
					asm_ack_data[15:0]  <= '0;
					if (hdr_type == FRAME_COMP_DATA)
						asm_ack_data[31:16] <= swap_bytes(hdr.comp.status);
					else
						asm_ack_data[31:16] <= '0;
					// Status 1 means success
					asm_ack_error <= (hdr_type == FRAME_COMP_EMPTY) && !hdr.comp.status[0];
				end
			end
			ST_REQ_WORD: begin
				asm_req.addr[15:0]   <= swap_bytes(ll_in.data[15:0]);
				asm_req.wdata[31:16] <= swap_bytes(ll_in.data[31:16]);
			end
			ST_WR_DATA: begin
				asm_req.wdata[15:0] <= swap_bytes(ll_in.data[15:0]);
			end
			ST_COMP_WORD: begin
				asm_ack_data[15:0] <= swap_bytes(ll_in.data[15:0]);
			end
			default: begin
			end
		endcase

		if (load_req)
			req <= asm_req;

		if (load_ack) begin
			ack_error <= asm_ack_error;
			ack_data  <= asm_ack_data;
		end
	end

	assign ack = '{valid: ack_valid, error: ack_error, data: ack_data};

endmodule

`default_nettype wire

// File: rtl/sccb_pkg.sv
`default_nettype none

package sccb_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Frame type codes

	// First byte of every frame on the link
	typedef enum logic [7:0] {
		FRAME_APB_WRITE  = 8'hfb,
		FRAME_APB_READ   = 8'h1c,
		FRAME_COMP_DATA  = 8'hfd,
		FRAME_COMP_EMPTY = 8'hf7
	} frame_type_e;

	////////////////////////////////////////////////////////////////////////////
	// Word layouts

	// One link layer word, byte 0 in the low bits
	typedef struct packed {
		logic        start;
		logic        valid;
		logic        commit;
		logic        drop;
		logic [31:0] data;
	} ll_word_t;

	// Word 0 of a request frame
	// Packed MSB first, so the last field lands in byte 0
	typedef struct packed {
		logic [7:0] addr_b2;
		logic [7:0] addr_b3;
		logic [7:0] seq;
		logic [7:0] frame_type;
	} req_header_t;

	// Word 0 of a completion frame
	// Status for empty completions, data bytes 3 and 2 otherwise
	typedef struct packed {
		logic [15:0] status;
		logic [7:0]  seq;
		logic [7:0]  frame_type;
	} comp_header_t;

	// Same word, two views picked by the type byte
	typedef union packed {
		req_header_t  req;
		comp_header_t comp;
	} frame_header_u;

	////////////////////////////////////////////////////////////////////////////
	// Stage records

	// Decoded request, decoder to requester
	typedef struct packed {
		logic        write;
		logic [31:0] addr;
		logic [31:0] wdata;
	} apb_request_t;

	// Finished transaction, requester to encoder
	typedef struct packed {
		logic        has_data;
		logic        success;
		logic [31:0] data;
	} completion_t;

	// Received completion report
	typedef struct packed {
		logic        valid;
		logic        error;
		logic [31:0] data;
	} ack_t;

	// APB requester outputs
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [31:0] paddr;
		logic [31:0] pwdata;
		logic [3:0]  pstrb;
	} apb_out_t;

	// APB completer responses
	typedef struct packed {
		logic        pready;
		logic        pslverr;
		logic [31:0] prdata;
	} apb_in_t;

	// Outgoing completion word
	typedef struct packed {
		logic        start;
		logic        valid;
		logic [31:0] data;
	} comp_word_t;

	// Multi-byte fields go high byte first on the wire
	function automatic logic [15:0] swap_bytes(input logic [15:0] v);
		return {v[7:0], v[15:8]};
	endfunction

endpackage

`default_nettype wire

// File: rtl/sccb_rx_bridge.sv
`default_nettype none

module sccb_rx_bridge
	import sccb_pkg::*;
#(
	parameter int CREDIT_INIT = 2
) (
	input wire           rx_clk,
	input wire           arst_n,
	input wire           link_up,
	input wire ll_word_t ll_in,
	input wire apb_in_t  apb_in,
	input wire           credit_return,
	output apb_out_t     apb_out,
	output ack_t         ack,
	output comp_word_t   comp_out
);

	// Decoder to requester
	apb_request_t req;
	logic         req_valid;
	logic         req_ready;

	// Requester to encoder
	completion_t  cmp;
	logic         cmp_valid;
	logic         cmp_ready;

	////////////////////////////////////////////////////////////////////////////
	// Link words in, requests and acks out

	sccb_frame_decoder i_sccb_frame_decoder (
		.rx_clk    (rx_clk),
		.arst_n    (arst_n),
		.link_up   (link_up),
		.ll_in     (ll_in),
		.req_ready (req_ready),
		.req       (req),
		.req_valid (req_valid),
		.ack       (ack)
	);

	// APB transaction per request
	sccb_apb_requester i_sccb_apb_requester (
		.rx_clk    (rx_clk),
		.arst_n    (arst_n),
		.req       (req),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.apb_out   (apb_out),
		.apb_in    (apb_in),
		.cmp       (cmp),
		.cmp_valid (cmp_valid),
		.cmp_ready (cmp_ready)
	);

	// Completion frames out under credit
	sccb_completion_encoder #(
		.CREDIT_INIT (CREDIT_INIT)
	) i_sccb_completion_encoder (
		.rx_clk        (rx_clk),
		.arst_n        (arst_n),
		.cmp           (cmp),
		.cmp_valid     (cmp_valid),
		.cmp_ready     (cmp_ready),
		.credit_return (credit_return),
		.comp_out      (comp_out)
	);

endmodule

`default_nettype wire

// File: sccb_rx_bridge.f
rtl/sccb_pkg.sv
rtl/sccb_frame_decoder.sv
rtl/sccb_apb_requester.sv
rtl/sccb_completion_encoder.sv
rtl/sccb_rx_bridge.sv
bench/sccb_rx_bridge_tb.sv
